// ==== hw/sat_pkg.sv ====
// sizes, variable and level records, implication and literal types, analyze states
package sat_pkg;

    // bin geometry
    localparam int NUM_VARS     = 8;
    localparam int NUM_LVLS     = 8;
    localparam int WIDTH_LVL    = 16;
    localparam int WIDTH_BIN_ID = 10;
    localparam int WIDTH_IDX    = 3;
    // local level runs 0..NUM_LVLS, one bit wider than an index
    localparam int WIDTH_LOCAL  = WIDTH_IDX + 1;

    typedef struct packed {
        logic                 assigned;
        logic                 value;
        logic                 decided;
        logic [WIDTH_LVL-1:0] level;
    } var_state_t;

    typedef struct packed {
        logic                    valid;
        logic                    flipped;
        logic [WIDTH_IDX-1:0]    var_idx;
        logic [WIDTH_BIN_ID-1:0] bin_id;
    } lvl_state_t;

    typedef struct packed {
        logic en;
        logic value;
    } imply_t;

    typedef struct packed {
        logic present;
        logic polarity;
    } lit_t;

    typedef enum logic [1:0] {
        ANALYZE_IDLE = 2'd0,
        FIND_LEARNTC = 2'd1,
        ADD_LEARNTC  = 2'd2,
        ANALYZE_DONE = 2'd3
    } analyze_state_e;

    localparam var_state_t VAR_STATE_CLR = '0;
    localparam lvl_state_t LVL_STATE_CLR = '0;

endpackage

// ==== hw/var_state8.sv ====
// eight variable records with implication, conflict, learnt literals and outer max level
module var_state8 (
    input  logic                                     clk,
    input  logic                                     rst,
    input  sat_pkg::imply_t [sat_pkg::NUM_VARS-1:0]  imply_i,
    input  logic                                     apply_imply_i,
    input  logic [sat_pkg::NUM_VARS-1:0]             decided_idx_i,
    input  logic                                     decide_value_i,
    input  logic [sat_pkg::WIDTH_LVL-1:0]            cur_lvl_i,
    input  logic [sat_pkg::WIDTH_LVL-1:0]            base_lvl_i,
    input  logic                                     apply_bkt_i,
    input  logic [sat_pkg::WIDTH_LVL-1:0]            bkt_lvl_i,
    input  logic [sat_pkg::NUM_VARS-1:0]             wr_states_i,
    input  sat_pkg::var_state_t [sat_pkg::NUM_VARS-1:0] var_states_i,
    output sat_pkg::var_state_t [sat_pkg::NUM_VARS-1:0] var_states_o,
    output logic [sat_pkg::NUM_VARS-1:0]             find_imply_o,
    output logic [sat_pkg::NUM_VARS-1:0]             find_conflict_o,
    output sat_pkg::lit_t [sat_pkg::NUM_VARS-1:0]    learnt_lit_o,
    output logic [sat_pkg::WIDTH_LVL-1:0]            max_lvl_o
);
    import sat_pkg::*;

    var_state_t [NUM_VARS-1:0] state_r;
    var_state_t [NUM_VARS-1:0] state_nxt;
    logic [WIDTH_LVL-1:0]      next_lvl;

    // a decision opens the next level
    assign next_lvl = cur_lvl_i + 1'b1;

    // priority: load, backtrack, decision, implication
    always_comb begin
        state_nxt = state_r;
        for (int i = 0; i < NUM_VARS; i++) begin
            if (wr_states_i[i]) begin
                state_nxt[i] = var_states_i[i];
            end else if (apply_bkt_i) begin
                if (state_r[i].assigned && state_r[i].level > bkt_lvl_i) begin
                    state_nxt[i] = VAR_STATE_CLR;
                end else if (state_r[i].assigned && state_r[i].decided &&
                             state_r[i].level == bkt_lvl_i) begin
                    // flip the decision, it stays a decision
                    state_nxt[i].value = ~state_r[i].value;
                end
            end else if (decided_idx_i[i]) begin
                state_nxt[i].assigned = 1'b1;
                state_nxt[i].value    = decide_value_i;
                state_nxt[i].decided  = 1'b1;
                state_nxt[i].level    = next_lvl;
            end else if (apply_imply_i && imply_i[i].en && !state_r[i].assigned) begin
                state_nxt[i].assigned = 1'b1;
                state_nxt[i].value    = imply_i[i].value;
                state_nxt[i].decided  = 1'b0;
                state_nxt[i].level    = cur_lvl_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_r <= '0;
        end else begin
            state_r <= state_nxt;
        end
    end

    assign var_states_o = state_r;

    always_comb begin
        max_lvl_o = '0;
        for (int i = 0; i < NUM_VARS; i++) begin
            find_imply_o[i] = state_r[i].assigned;
            // implication against a stored value
            find_conflict_o[i] = state_r[i].assigned && imply_i[i].en &&
                                 (imply_i[i].value != state_r[i].value);
            // decision-based clause, negated decisions
            learnt_lit_o[i].present  = state_r[i].assigned && state_r[i].decided;
            learnt_lit_o[i].polarity = ~state_r[i].value;
            // only levels from outside this bin
            if (state_r[i].assigned && state_r[i].level < base_lvl_i &&
                state_r[i].level > max_lvl_o) begin
                max_lvl_o = state_r[i].level;
            end
        end
    end

    // decisions arrive one variable at a time
    assert property (@(posedge clk) disable iff (!rst) $onehot0(decided_idx_i));

endmodule

// ==== hw/lvl_state8.sv ====
// per-level decision records, flip flags and the deepest unflipped level search
module lvl_state8 (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [sat_pkg::NUM_VARS-1:0]                decided_idx_i,
    input  logic [sat_pkg::WIDTH_IDX-1:0]               cur_local_lvl_i,
    input  logic [sat_pkg::WIDTH_BIN_ID-1:0]            cur_bin_num_i,
    input  logic                                        apply_bkt_i,
    input  logic [sat_pkg::WIDTH_LOCAL-1:0]             bkt_local_lvl_i,
    input  logic [sat_pkg::NUM_LVLS-1:0]                wr_states_i,
    input  sat_pkg::lvl_state_t [sat_pkg::NUM_LVLS-1:0] lvl_states_i,
    output sat_pkg::lvl_state_t [sat_pkg::NUM_LVLS-1:0] lvl_states_o,
    output logic [sat_pkg::NUM_LVLS-1:0]                findindex_o,
    output logic [sat_pkg::WIDTH_BIN_ID-1:0]            bkt_bin_o,
    output logic                                        flip_next_o
);
    import sat_pkg::*;

    lvl_state_t [NUM_LVLS-1:0] state_r;
    lvl_state_t [NUM_LVLS-1:0] state_nxt;
    logic [WIDTH_IDX-1:0]      decided_var;

    always_comb begin
        decided_var = '0;
        for (int i = 0; i < NUM_VARS; i++) begin
            if (decided_idx_i[i]) begin
                decided_var = WIDTH_IDX'(i);
            end
        end
    end

    // entry the next decision will take
    assign flip_next_o = state_r[cur_local_lvl_i].valid && state_r[cur_local_lvl_i].flipped;

    always_comb begin
        state_nxt = state_r;
        for (int j = 0; j < NUM_LVLS; j++) begin
            if (wr_states_i[j]) begin
                state_nxt[j] = lvl_states_i[j];
            end else if (apply_bkt_i) begin
                if (WIDTH_LOCAL'(j) >= bkt_local_lvl_i) begin
                    state_nxt[j] = LVL_STATE_CLR;
                end else if (WIDTH_LOCAL'(j) + 1'b1 == bkt_local_lvl_i) begin
                    state_nxt[j].flipped = 1'b1;
                end
            end else if (|decided_idx_i && WIDTH_IDX'(j) == cur_local_lvl_i) begin
                state_nxt[j].valid   = 1'b1;
                state_nxt[j].flipped = flip_next_o;
                state_nxt[j].var_idx = decided_var;
                state_nxt[j].bin_id  = cur_bin_num_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_r <= '0;
        end else begin
            state_r <= state_nxt;
        end
    end

    assign lvl_states_o = state_r;

    // deepest level still worth flipping
    always_comb begin
        findindex_o = '0;
        for (int j = 0; j < NUM_LVLS; j++) begin
            if (state_r[j].valid && !state_r[j].flipped) begin
                findindex_o    = '0;
                findindex_o[j] = 1'b1;
            end
        end
    end

    // nothing left here, so the bin before this one
    always_comb begin
        bkt_bin_o = cur_bin_num_i - 1'b1;
        for (int j = 0; j < NUM_LVLS; j++) begin
            if (findindex_o[j]) begin
                bkt_bin_o = state_r[j].bin_id;
            end
        end
    end

endmodule

// ==== hw/decision.sv ====
// next decision variable, its polarity and the local level counter
module decision (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start_i,
    input  logic [sat_pkg::NUM_VARS-1:0]    assigned_i,
    input  logic                            flip_next_i,
    input  logic                            apply_bkt_i,
    input  logic [sat_pkg::WIDTH_LOCAL-1:0] bkt_local_lvl_i,
    output logic [sat_pkg::NUM_VARS-1:0]    decided_idx_o,
    output logic                            decide_value_o,
    output logic [sat_pkg::WIDTH_LOCAL-1:0] cur_local_lvl_o,
    output logic                            done_o
);
    import sat_pkg::*;

    logic [NUM_VARS-1:0] first_free;

    // lowest zero bit of the assigned mask, zero when all are taken
    assign first_free = ~assigned_i & (assigned_i + 1'b1);

    assign decided_idx_o = start_i ? first_free : '0;

    // 0 on a fresh level, 1 once that level was flipped
    assign decide_value_o = flip_next_i;

    always_ff @(posedge clk) begin
        if (!rst) begin
            cur_local_lvl_o <= '0;
            done_o          <= 1'b0;
        end else begin
            done_o <= start_i;
            if (apply_bkt_i) begin
                cur_local_lvl_o <= bkt_local_lvl_i;
            end else if (|decided_idx_o) begin
                cur_local_lvl_o <= cur_local_lvl_o + 1'b1;
            end
        end
    end

    // a decision needs a free local level in the bin
    assert property (@(posedge clk) disable iff (!rst)
        (|decided_idx_o && !apply_bkt_i) |-> (cur_local_lvl_o < WIDTH_LOCAL'(NUM_LVLS)));

endmodule

// ==== hw/state_list.sv ====
// bin state keeper: base level, imply and analyze control, backtrack level and done strobes
module state_list (
    input  logic                                        clk,
    input  logic                                        rst,

    input  sat_pkg::imply_t [sat_pkg::NUM_VARS-1:0]     imply_i,
    output sat_pkg::var_state_t [sat_pkg::NUM_VARS-1:0] var_states_o,
    output sat_pkg::lit_t [sat_pkg::NUM_VARS-1:0]       learnt_lit_o,

    // decide
    input  logic                                        start_decision_i,
    input  logic [sat_pkg::WIDTH_BIN_ID-1:0]            cur_bin_num_i,
    output logic [sat_pkg::WIDTH_LVL-1:0]               cur_lvl_o,
    output logic                                        done_decision_o,

    // imply
    input  logic                                        apply_imply_i,
    output logic                                        done_imply_o,
    output logic                                        find_conflict_o,

    // analyze
    input  logic                                        apply_analyze_i,
    output logic                                        add_learntc_en_o,
    output logic                                        done_analyze_o,
    output logic [sat_pkg::WIDTH_BIN_ID-1:0]            bkt_bin_o,
    output logic [sat_pkg::WIDTH_LVL-1:0]               bkt_lvl_o,

    // backtrack inside the bin
    input  logic                                        apply_bkt_cur_bin_i,
    output logic                                        done_bkt_cur_bin_o,

    // direct loads
    input  logic [sat_pkg::NUM_VARS-1:0]                wr_var_states_i,
    input  sat_pkg::var_state_t [sat_pkg::NUM_VARS-1:0] var_states_i,
    input  logic [sat_pkg::NUM_LVLS-1:0]                wr_lvl_states_i,
    input  sat_pkg::lvl_state_t [sat_pkg::NUM_LVLS-1:0] lvl_states_i,
    output sat_pkg::lvl_state_t [sat_pkg::NUM_LVLS-1:0] lvl_states_o,
    input  logic                                        base_lvl_en_i,
    input  logic [sat_pkg::WIDTH_LVL-1:0]               base_lvl_i
);
    import sat_pkg::*;

    logic [WIDTH_LVL-1:0]   base_lvl_r;
    logic [WIDTH_LVL-1:0]   max_lvl;
    logic [NUM_LVLS-1:0]    findindex;
    logic [WIDTH_LOCAL-1:0] bkt_local_lvl;
    logic [WIDTH_LOCAL-1:0] cur_local_lvl;
    logic [NUM_VARS-1:0]    decided_idx;
    logic                   decide_value;
    logic                   flip_next;
    logic [NUM_VARS-1:0]    find_imply_cur;
    logic [NUM_VARS-1:0]    find_imply_pre;
    logic [NUM_VARS-1:0]    find_conflict_cur;
    logic [NUM_VARS-1:0]    find_conflict_pre;
    analyze_state_e         ana_state;
    analyze_state_e         ana_state_nxt;

    decision u_decision (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start_decision_i),
        .assigned_i     (find_imply_cur),
        .flip_next_i    (flip_next),
        .apply_bkt_i    (apply_bkt_cur_bin_i),
        .bkt_local_lvl_i(bkt_local_lvl),
        .decided_idx_o  (decided_idx),
        .decide_value_o (decide_value),
        .cur_local_lvl_o(cur_local_lvl),
        .done_o         (done_decision_o)
    );

    var_state8 u_var_state8 (
        .clk            (clk),
        .rst            (rst),
        .imply_i        (imply_i),
        .apply_imply_i  (apply_imply_i),
        .decided_idx_i  (decided_idx),
        .decide_value_i (decide_value),
        .cur_lvl_i      (cur_lvl_o),
        .base_lvl_i     (base_lvl_r),
        .apply_bkt_i    (apply_bkt_cur_bin_i),
        .bkt_lvl_i      (bkt_lvl_o),
        .wr_states_i    (wr_var_states_i),
        .var_states_i   (var_states_i),
        .var_states_o   (var_states_o),
        .find_imply_o   (find_imply_cur),
        .find_conflict_o(find_conflict_cur),
        .learnt_lit_o   (learnt_lit_o),
        .max_lvl_o      (max_lvl)
    );

    lvl_state8 u_lvl_state8 (
        .clk            (clk),
        .rst            (rst),
        .decided_idx_i  (decided_idx),
        .cur_local_lvl_i(cur_local_lvl[WIDTH_IDX-1:0]),
        .cur_bin_num_i  (cur_bin_num_i),
        .apply_bkt_i    (apply_bkt_cur_bin_i),
        .bkt_local_lvl_i(bkt_local_lvl),
        .wr_states_i    (wr_lvl_states_i),
        .lvl_states_i   (lvl_states_i),
        .lvl_states_o   (lvl_states_o),
        .findindex_o    (findindex),
        .bkt_bin_o      (bkt_bin_o),
        .flip_next_o    (flip_next)
    );

    assign cur_lvl_o       = base_lvl_r + WIDTH_LVL'(cur_local_lvl);
    assign find_conflict_o = |find_conflict_cur;

    always_ff @(posedge clk) begin
        if (!rst) begin
            base_lvl_r        <= '0;
            find_imply_pre    <= '0;
            find_conflict_pre <= '0;
            done_imply_o      <= 1'b0;
        end else begin
            if (base_lvl_en_i) begin
                base_lvl_r <= base_lvl_i;
            end
            find_imply_pre    <= find_imply_cur;
            find_conflict_pre <= find_conflict_cur;
            // settled mask or a conflict ends propagation
            done_imply_o <= apply_imply_i &&
                            (find_imply_cur == find_imply_pre || find_conflict_o);
        end
    end

    // analyze FSM
    always_comb begin
        ana_state_nxt = ana_state;
        unique case (ana_state)
            ANALYZE_IDLE: if (apply_analyze_i) ana_state_nxt = FIND_LEARNTC;
            FIND_LEARNTC: if (find_conflict_cur == find_conflict_pre) ana_state_nxt = ADD_LEARNTC;
            ADD_LEARNTC:  ana_state_nxt = ANALYZE_DONE;
            ANALYZE_DONE: if (!apply_analyze_i) ana_state_nxt = ANALYZE_IDLE;
            default:      ana_state_nxt = ANALYZE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ana_state        <= ANALYZE_IDLE;
            add_learntc_en_o <= 1'b0;
            done_analyze_o   <= 1'b0;
        end else begin
            ana_state        <= ana_state_nxt;
            add_learntc_en_o <= (ana_state == ADD_LEARNTC);
            done_analyze_o   <= (ana_state == ANALYZE_DONE) && apply_analyze_i;
        end
    end

    // one-hot level to local backtrack level, index plus one
    always_comb begin
        bkt_local_lvl = '0;
        for (int j = 0; j < NUM_LVLS; j++) begin
            if (findindex[j]) begin
                bkt_local_lvl = WIDTH_LOCAL'(j + 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            bkt_lvl_o          <= '0;
            done_bkt_cur_bin_o <= 1'b0;
        end else begin
            // every level flipped, go back to the outer bins
            if (findindex == '0) begin
                bkt_lvl_o <= max_lvl;
            end else begin
                bkt_lvl_o <= base_lvl_r + WIDTH_LVL'(bkt_local_lvl);
            end
            done_bkt_cur_bin_o <= apply_bkt_cur_bin_i;
        end
    end

    // learnt clause goes out before analysis reports done
    assert property (@(posedge clk) disable iff (!rst) !(add_learntc_en_o && done_analyze_o));

    // backtrack inside the bin needs an unflipped level
    assert property (@(posedge clk) disable iff (!rst) apply_bkt_cur_bin_i |-> |findindex);

endmodule

// ==== sim/clk_gen.sv ====
// testbench clock and active low reset generator
module clk_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam time HALF_PERIOD = 50ns;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // reset held for two rising edges
    initial begin
        rst_o = 1'b0;
        repeat (2) @(posedge clk_o);
        rst_o <= 1'b1;
    end

endmodule

// ==== sim/tb_state_list.sv ====
// state_list testbench with reference model, stimulus, compare task and timeout
module tb_state_list;
    timeunit 1ns;
    timeprecision 1ps;
    import sat_pkg::*;

    localparam int CW         = 160;
    localparam int NUM_ROUNDS = 6;
    // one round is a decision, an imply, an analysis and a backtrack
    localparam int MAX_CYCLES = (NUM_ROUNDS + NUM_LVLS + 1) * 80 + 100;
    localparam logic [WIDTH_LVL-1:0]    BASE_LVL = 16'h0010;
    localparam logic [WIDTH_BIN_ID-1:0] BIN_NUM  = 10'd3;

    typedef struct packed {
        logic                    found;
        logic [WIDTH_LOCAL-1:0]  local_lvl;
        logic [WIDTH_BIN_ID-1:0] bin;
        logic [WIDTH_LVL-1:0]    lvl;
    } bkt_ref_t;

    logic                                clk;
    logic                                rst;
    imply_t [NUM_VARS-1:0]               imply_i;
    var_state_t [NUM_VARS-1:0]           var_states_o;
    lit_t [NUM_VARS-1:0]                 learnt_lit_o;
    logic                                start_decision_i;
    logic [WIDTH_BIN_ID-1:0]             cur_bin_num_i;
    logic [WIDTH_LVL-1:0]                cur_lvl_o;
    logic                                done_decision_o;
    logic                                apply_imply_i;
    logic                                done_imply_o;
    logic                                find_conflict_o;
    logic                                apply_analyze_i;
    logic                                add_learntc_en_o;
    logic                                done_analyze_o;
    logic [WIDTH_BIN_ID-1:0]             bkt_bin_o;
    logic [WIDTH_LVL-1:0]                bkt_lvl_o;
    logic                                apply_bkt_cur_bin_i;
    logic                                done_bkt_cur_bin_o;
    logic [NUM_VARS-1:0]                 wr_var_states_i;
    var_state_t [NUM_VARS-1:0]           var_states_i;
    logic [NUM_LVLS-1:0]                 wr_lvl_states_i;
    lvl_state_t [NUM_LVLS-1:0]           lvl_states_i;
    lvl_state_t [NUM_LVLS-1:0]           lvl_states_o;
    logic                                base_lvl_en_i;
    logic [WIDTH_LVL-1:0]                base_lvl_i;

    // reference model of the bin
    var_state_t [NUM_VARS-1:0] m_var;
    lvl_state_t [NUM_LVLS-1:0] m_lvl;
    logic [WIDTH_LVL-1:0]      m_base;
    int                        m_local;
    imply_t [NUM_VARS-1:0]     imp;
    logic                      conflict;
    integer                    seed;
    int                        cycles;

    clk_gen u_clk_gen (
        .clk_o(clk),
        .rst_o(rst)
    );

    state_list dut0 (.*);

    task automatic check(input string name, input logic [CW-1:0] got, input logic [CW-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %0h expected %0h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    // deepest valid unflipped level, else the highest level from outside the bin
    function automatic bkt_ref_t backtrack_target();
        bkt_ref_t             r;
        logic [WIDTH_LVL-1:0] outer;
        r = '0;
        outer = '0;
        r.bin = BIN_NUM - 10'd1;
        for (int j = 0; j < NUM_LVLS; j++) begin
            if (m_lvl[j].valid && !m_lvl[j].flipped) begin
                r.found = 1'b1;
                r.local_lvl = WIDTH_LOCAL'(j + 1);
                r.bin = m_lvl[j].bin_id;
            end
        end
        for (int i = 0; i < NUM_VARS; i++) begin
            if (m_var[i].assigned && m_var[i].level < m_base && m_var[i].level > outer) begin
                outer = m_var[i].level;
            end
        end
        r.lvl = r.found ? m_base + WIDTH_LVL'(r.local_lvl) : outer;
        return r;
    endfunction

    // present bit and negated value of each decision
    function automatic logic [2*NUM_VARS-1:0] negated_decisions();
        logic [2*NUM_VARS-1:0] v;
        for (int i = 0; i < NUM_VARS; i++) begin
            v[2*i+1] = m_var[i].assigned && m_var[i].decided;
            v[2*i]   = v[2*i+1] && !m_var[i].value;
        end
        return v;
    endfunction

    function automatic logic [2*NUM_VARS-1:0] dut_learnt();
        logic [2*NUM_VARS-1:0] v;
        for (int i = 0; i < NUM_VARS; i++) begin
            v[2*i+1] = learnt_lit_o[i].present;
            v[2*i]   = learnt_lit_o[i].present && learnt_lit_o[i].polarity;
        end
        return v;
    endfunction

    // valid level entries of the DUT not yet flipped
    function automatic int unflipped_levels();
        int n;
        n = 0;
        for (int j = 0; j < NUM_LVLS; j++) begin
            if (lvl_states_o[j].valid && !lvl_states_o[j].flipped) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic verify_state();
        check("var_states_o", CW'(var_states_o), CW'(m_var));
        check("lvl_states_o", CW'(lvl_states_o), CW'(m_lvl));
        check("cur_lvl_o", CW'(cur_lvl_o), CW'(m_base + WIDTH_LVL'(m_local)));
    endtask

    task automatic preload_outer();
        @(posedge clk);
        wr_var_states_i <= 8'hc0;
        var_states_i[7] <= {1'b1, 1'b1, 1'b0, 16'h000c};
        var_states_i[6] <= {1'b1, 1'b0, 1'b0, 16'h0009};
        base_lvl_en_i   <= 1'b1;
        base_lvl_i      <= BASE_LVL;
        @(posedge clk);
        wr_var_states_i <= '0;
        base_lvl_en_i   <= 1'b0;
        m_var[7] = {1'b1, 1'b1, 1'b0, 16'h000c};
        m_var[6] = {1'b1, 1'b0, 1'b0, 16'h0009};
        m_base = BASE_LVL;
        @(negedge clk);
        verify_state();
    endtask

    task automatic make_decision();
        int   pick;
        logic flip;
        pick = -1;
        for (int i = NUM_VARS - 1; i >= 0; i--) begin
            if (!m_var[i].assigned) begin
                pick = i;
            end
        end
        flip = m_lvl[m_local].valid && m_lvl[m_local].flipped;
        @(posedge clk);
        start_decision_i <= 1'b1;
        @(posedge clk);
        start_decision_i <= 1'b0;
        if (pick >= 0) begin
            m_var[pick] = {1'b1, flip, 1'b1, m_base + WIDTH_LVL'(m_local + 1)};
            m_lvl[m_local] = {1'b1, flip, WIDTH_IDX'(pick), BIN_NUM};
            m_local++;
        end
        @(negedge clk);
        check("done_decision_o", CW'(done_decision_o), CW'(1'b1));
        verify_state();
        @(negedge clk);
        check("done_decision_o", CW'(done_decision_o), CW'(1'b0));
    endtask

    task automatic apply_implications(input imply_t [NUM_VARS-1:0] im, output logic conf);
        int n;
        conf = 1'b0;
        for (int i = 0; i < NUM_VARS; i++) begin
            if (im[i].en && !m_var[i].assigned) begin
                m_var[i] = {1'b1, im[i].value, 1'b0, m_base + WIDTH_LVL'(m_local)};
            end
            if (im[i].en && m_var[i].value != im[i].value) begin
                conf = 1'b1;
            end
        end
        @(posedge clk);
        imply_i       <= im;
        apply_imply_i <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!done_imply_o && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!done_imply_o) begin
            abort_run("done_imply_o never rose while implications were applied");
        end
        check("find_conflict_o", CW'(find_conflict_o), CW'(conf));
        verify_state();
        @(posedge clk);
        apply_imply_i <= 1'b0;
    endtask

    task automatic run_analysis();
        bkt_ref_t r;
        int       n;
        r = backtrack_target();
        @(posedge clk);
        apply_analyze_i <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!add_learntc_en_o && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!add_learntc_en_o) begin
            abort_run("add_learntc_en_o never pulsed during analysis");
        end
        check("learnt_lit_o", CW'(dut_learnt()), CW'(negated_decisions()));
        @(negedge clk);
        n = 0;
        while (!done_analyze_o && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!done_analyze_o) begin
            abort_run("done_analyze_o never rose after the learnt clause");
        end
        // done holds while the request is held
        repeat (3) begin
            check("done_analyze_o", CW'(done_analyze_o), CW'(1'b1));
            check("add_learntc_en_o", CW'(add_learntc_en_o), CW'(1'b0));
            @(negedge clk);
        end
        check("bkt_lvl_o", CW'(bkt_lvl_o), CW'(r.lvl));
        check("bkt_bin_o", CW'(bkt_bin_o), CW'(r.bin));
        @(posedge clk);
        apply_analyze_i <= 1'b0;
        repeat (2) @(negedge clk);
        check("done_analyze_o", CW'(done_analyze_o), CW'(1'b0));
    endtask

    task automatic backtrack_in_bin();
        bkt_ref_t r;
        int       bl;
        r = backtrack_target();
        bl = int'(r.local_lvl);
        for (int i = 0; i < NUM_VARS; i++) begin
            if (m_var[i].assigned && m_var[i].level > r.lvl) begin
                m_var[i] = '0;
            end else if (m_var[i].assigned && m_var[i].decided && m_var[i].level == r.lvl) begin
                m_var[i].value = ~m_var[i].value;
            end
        end
        for (int j = 0; j < NUM_LVLS; j++) begin
            if (j >= bl) begin
                m_lvl[j] = '0;
            end else if (j + 1 == bl) begin
                m_lvl[j].flipped = 1'b1;
            end
        end
        m_local = bl;
        @(posedge clk);
        apply_bkt_cur_bin_i <= 1'b1;
        @(posedge clk);
        apply_bkt_cur_bin_i <= 1'b0;
        @(negedge clk);
        check("done_bkt_cur_bin_o", CW'(done_bkt_cur_bin_o), CW'(1'b1));
        verify_state();
        @(negedge clk);
        check("done_bkt_cur_bin_o", CW'(done_bkt_cur_bin_o), CW'(1'b0));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("simulation ran past %0d cycles without finishing", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

    initial begin
        seed = 32'h9fe3;
        cycles = 0;
        imply_i = '0;
        start_decision_i = 1'b0;
        cur_bin_num_i = BIN_NUM;
        apply_imply_i = 1'b0;
        apply_analyze_i = 1'b0;
        apply_bkt_cur_bin_i = 1'b0;
        wr_var_states_i = '0;
        var_states_i = '0;
        wr_lvl_states_i = '0;
        lvl_states_i = '0;
        base_lvl_en_i = 1'b0;
        base_lvl_i = '0;
        m_var = '0;
        m_lvl = '0;
        m_base = '0;
        m_local = 0;
        wait (rst === 1'b1);
        @(negedge clk);
        check("done and enable outputs", CW'({done_decision_o, done_imply_o,
              add_learntc_en_o, done_analyze_o, done_bkt_cur_bin_o}), CW'(5'b0));
        verify_state();
        preload_outer();
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            make_decision();
            for (int i = 0; i < NUM_VARS; i++) begin
                imp[i].en    = 1'($random(seed));
                imp[i].value = 1'($random(seed));
            end
            apply_implications(imp, conflict);
            if (conflict) begin
                run_analysis();
                if (backtrack_target().found) begin
                    backtrack_in_bin();
                end
            end
        end
        // var 7 holds 1 from outside, so this always conflicts
        imp = '0;
        imp[7] = {1'b1, 1'b0};
        for (int k = 0; k <= NUM_LVLS; k++) begin
            apply_implications(imp, conflict);
            check("find_conflict_o", CW'(find_conflict_o), CW'(1'b1));
            run_analysis();
            if (!backtrack_target().found) begin
                break;
            end
            backtrack_in_bin();
        end
        check("unflipped levels left", CW'(unflipped_levels()), CW'(0));
        check("bkt_lvl_o", CW'(bkt_lvl_o), CW'(16'h000c));
        check("bkt_bin_o", CW'(bkt_bin_o), CW'(BIN_NUM - 10'd1));
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== src.f ====
hw/sat_pkg.sv
hw/var_state8.sv
hw/lvl_state8.sv
hw/decision.sv
hw/state_list.sv
sim/clk_gen.sv
sim/tb_state_list.sv

// ==== Makefile ====
TOP := tb_state_list
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
